// ==== filelist.f ====
+incdir+.
mem_bus_pkg.sv
icache_pkg.sv
icache_mem.sv
icache_ctrl.sv
dmem_port.sv
mem_arbiter.sv
mem_subsys.sv
tb_mem_model.sv
tb_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_mem_subsys -f filelist.f -o sim_mem_subsys

# The simulator exits nonzero on an error, the log decides the result
./obj_dir/sim_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_subsys;

  localparam int SEED        = 34;
  localparam int N_FETCH     = 300;
  localparam int N_DATA      = 300;
  localparam int CYCLE_LIMIT = (N_FETCH + N_DATA) * 30;
  localparam int POOL_SIZE   = 48;  // More fetch addresses than lines so some evict
  localparam int HIT_LAT     = 2;   // Mid-cycle samples from the sampling edge to ack

  logic                   clock = 1'b0;
  logic                   arst_n;
  logic                   ic_cyc;
  logic                   ic_stb;
  logic [`CPU_ADDR_W-1:0] ic_adr;
  logic [`XLEN-1:0]       ic_dat_r;
  logic                   ic_ack;
  logic                   dc_cyc;
  logic                   dc_stb;
  logic                   dc_we;
  logic [`CPU_ADDR_W-1:0] dc_adr;
  logic [`XLEN-1:0]       dc_dat_w;
  logic [`XLEN-1:0]       dc_dat_r;
  logic                   dc_ack;
  mem_bus_pkg::bus_cmd_e  proc2mem_command;
  logic [`XLEN-1:0]       proc2mem_addr;
  logic [`XLEN-1:0]       proc2mem_data;
  mem_bus_pkg::mem_tag_t  mem2proc_response;
  logic [`XLEN-1:0]       mem2proc_data;
  mem_bus_pkg::mem_tag_t  mem2proc_tag;

  integer                 seed;
  int                     cycle_count = 0;
  int                     hits = 0;
  int                     misses = 0;
  int                     loads = 0;
  int                     stores = 0;
  logic [`XLEN-1:0]       ref_mem [0:8191];
  logic                   cache_valid [0:`IC_LINES-1];
  logic [`IC_TAG_W-1:0]   cache_tag [0:`IC_LINES-1];
  logic [`CPU_ADDR_W-1:0] pool [0:POOL_SIZE-1];
  logic [`CPU_ADDR_W-1:0] fetch_adr [0:N_FETCH-1];
  logic [`CPU_ADDR_W-1:0] data_adr [0:N_DATA-1];
  logic                   data_we [0:N_DATA-1];
  logic [`XLEN-1:0]       data_wdata [0:N_DATA-1];

  mem_subsys dut (.*);

  tb_mem_model #(.SEED(SEED)) mem_model (
    .clock             (clock),
    .arst_n            (arst_n),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  always #20 clock = ~clock;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] exp);
    stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_on_error($sformatf("Timeout: traffic did not finish within %0d cycles",
                              CYCLE_LIMIT));
    end
  end

  function automatic int pick(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic build_stimulus();
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = {8'(pick(0, 127)), 5'(pick(0, 31)), 3'b000};  // Below 0x8000
    end
    for (int i = 0; i < N_FETCH; i++) begin
      fetch_adr[i] = pool[pick(0, POOL_SIZE - 1)];
    end
    for (int i = 0; i < N_DATA; i++) begin
      data_adr[i]   = 16'h8000 + 16'(pick(0, 63) * 8);  // Small area so loads see stores
      data_we[i]    = 1'(pick(0, 1));
      data_wdata[i] = {$random(seed), $random(seed)};
    end
  endtask

  task automatic run_fetch(input logic [`CPU_ADDR_W-1:0] adr);
    logic [`IC_IDX_W-1:0] idx;
    logic [`IC_TAG_W-1:0] tag;
    logic                 predict_hit;
    logic [`XLEN-1:0]     expected;
    int                   cycles;
    int                   load_cycles;
    int                   load_accepts;

    idx          = adr[7:3];
    tag          = adr[15:8];
    predict_hit  = cache_valid[idx] && (cache_tag[idx] == tag);
    expected     = ref_mem[adr[15:3]];
    cycles       = 0;
    load_cycles  = 0;
    load_accepts = 0;
    @(posedge clock);
    #1;
    ic_cyc = 1'b1;
    ic_stb = 1'b1;
    ic_adr = adr;
    @(posedge clock);  // Request sampled here
    do begin
      @(negedge clock);
      cycles++;
      if (proc2mem_command == mem_bus_pkg::BUS_LOAD && proc2mem_addr == `XLEN'(adr)) begin
        load_cycles++;
        if (mem2proc_response != mem_bus_pkg::TAG_NONE) begin
          load_accepts++;
        end
      end
    end while (!ic_ack);
    assert (ic_dat_r == expected) else report_mismatch("ic_dat_r", ic_dat_r, expected);
    if (predict_hit) begin
      hits++;
      assert (cycles == HIT_LAT) else stop_on_error($sformatf(
        "Fetch hit at 0x%h acked after %0d cycles instead of %0d", adr, cycles, HIT_LAT));
      assert (load_cycles == 0) else stop_on_error($sformatf(
        "Fetch hit at 0x%h put a load for its address on the memory bus", adr));
    end else begin
      misses++;
      assert (load_accepts == 1) else stop_on_error($sformatf(
        "Fetch miss at 0x%h had %0d accepted loads instead of one", adr, load_accepts));
      cache_valid[idx] = 1'b1;
      cache_tag[idx]   = tag;
    end
    @(posedge clock);
    #1;
    ic_cyc = 1'b0;
    ic_stb = 1'b0;
  endtask

  task automatic run_data(input logic [`CPU_ADDR_W-1:0] adr, input logic we,
                          input logic [`XLEN-1:0] wdata);
    mem_bus_pkg::bus_cmd_e exp_cmd;
    logic [`XLEN-1:0]      expected;
    logic                  accepted;

    exp_cmd  = we ? mem_bus_pkg::BUS_STORE : mem_bus_pkg::BUS_LOAD;
    expected = ref_mem[adr[15:3]];
    accepted = 1'b0;
    @(posedge clock);
    #1;
    dc_cyc   = 1'b1;
    dc_stb   = 1'b1;
    dc_we    = we;
    dc_adr   = adr;
    dc_dat_w = wdata;
    @(posedge clock);
    do begin
      @(negedge clock);
      if (!accepted && !dc_ack) begin
        // Data side owns the bus until accepted
        assert (proc2mem_command == exp_cmd) else report_mismatch("proc2mem_command",
          `XLEN'(proc2mem_command), `XLEN'(exp_cmd));
        assert (proc2mem_addr == `XLEN'(adr)) else report_mismatch("proc2mem_addr",
          proc2mem_addr, `XLEN'(adr));
        if (we) begin
          assert (proc2mem_data == wdata) else report_mismatch("proc2mem_data",
            proc2mem_data, wdata);
        end
        accepted = (mem2proc_response != mem_bus_pkg::TAG_NONE);
      end
    end while (!dc_ack);
    assert (accepted) else stop_on_error($sformatf(
      "Data access at 0x%h acked before memory accepted it", adr));
    if (we) begin
      stores++;
      ref_mem[adr[15:3]] = wdata;
    end else begin
      loads++;
      assert (dc_dat_r == expected) else report_mismatch("dc_dat_r", dc_dat_r, expected);
    end
    @(posedge clock);
    #1;
    dc_cyc = 1'b0;
    dc_stb = 1'b0;
  endtask

  initial begin
    seed     = SEED;
    arst_n   = 1'b0;
    ic_cyc   = 1'b0;
    ic_stb   = 1'b0;
    ic_adr   = '0;
    dc_cyc   = 1'b0;
    dc_stb   = 1'b0;
    dc_we    = 1'b0;
    dc_adr   = '0;
    dc_dat_w = '0;
    build_stimulus();
    for (int i = 0; i < `IC_LINES; i++) begin
      cache_valid[i] = 1'b0;
      cache_tag[i]   = '0;
    end
    repeat (2) @(posedge clock);
    #1;
    arst_n = 1'b1;
    for (int i = 0; i < 8192; i++) begin
      ref_mem[i] = mem_model.mem[i];
    end
    @(negedge clock);
    assert (!ic_ack) else report_mismatch("ic_ack", `XLEN'(ic_ack), '0);
    assert (!dc_ack) else report_mismatch("dc_ack", `XLEN'(dc_ack), '0);
    assert (proc2mem_command == mem_bus_pkg::BUS_NONE) else report_mismatch(
      "proc2mem_command", `XLEN'(proc2mem_command), `XLEN'(mem_bus_pkg::BUS_NONE));
    fork
      begin
        for (int i = 0; i < N_FETCH; i++) begin
          run_fetch(fetch_adr[i]);
        end
      end
      begin
        for (int i = 0; i < N_DATA; i++) begin
          run_data(data_adr[i], data_we[i], data_wdata[i]);
        end
      end
    join
    $display("Fetches %0d hits %0d misses, data %0d loads %0d stores",
             hits, misses, loads, stores);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_model #(
  parameter int SEED = 34
) (
  input  logic                  clock,
  input  logic                  arst_n,
  input  mem_bus_pkg::bus_cmd_e proc2mem_command,
  input  logic [`XLEN-1:0]      proc2mem_addr,
  input  logic [`XLEN-1:0]      proc2mem_data,
  output mem_bus_pkg::mem_tag_t mem2proc_response,
  output logic [`XLEN-1:0]      mem2proc_data,
  output mem_bus_pkg::mem_tag_t mem2proc_tag
);

  localparam int WORDS = 8192;

  logic [`XLEN-1:0]      mem [0:WORDS-1];
  integer                seed;
  int                    cycle;
  int                    wait_cnt;      // Cycles the current command has waited
  int                    accept_delay;
  mem_bus_pkg::mem_tag_t next_tag;
  mem_bus_pkg::bus_cmd_e s_cmd;
  logic [`XLEN-1:0]      s_addr;
  logic [`XLEN-1:0]      s_data;
  mem_bus_pkg::mem_tag_t s_resp;
  mem_bus_pkg::mem_tag_t ret_tag [$];   // Loads waiting to return
  logic [`XLEN-1:0]      ret_data [$];
  int                    ret_due [$];

  function automatic int pick(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  initial begin
    seed              = SEED;
    mem2proc_response = mem_bus_pkg::TAG_NONE;
    mem2proc_tag      = mem_bus_pkg::TAG_NONE;
    mem2proc_data     = '0;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {$random(seed), $random(seed)};
    end
  end

  // Bus values sampled mid-cycle for the next rising edge
  always @(negedge clock) begin
    s_cmd  = proc2mem_command;
    s_addr = proc2mem_addr;
    s_data = proc2mem_data;
    s_resp = mem2proc_response;
  end

  always @(posedge clock) begin
    if (!arst_n) begin
      cycle             = 0;
      wait_cnt          = 0;
      accept_delay      = pick(0, 3);
      next_tag          = 4'd1;
      mem2proc_response = mem_bus_pkg::TAG_NONE;
      mem2proc_tag      = mem_bus_pkg::TAG_NONE;
      mem2proc_data     = '0;
      ret_tag.delete();
      ret_data.delete();
      ret_due.delete();
    end else begin
      cycle++;
      if (s_resp != mem_bus_pkg::TAG_NONE) begin
        if (s_cmd == mem_bus_pkg::BUS_STORE) begin
          mem[s_addr[15:3]] = s_data;  // Store lands at acceptance
        end else if (s_cmd == mem_bus_pkg::BUS_LOAD) begin
          ret_tag.push_back(s_resp);
          ret_data.push_back(mem[s_addr[15:3]]);
          ret_due.push_back(cycle + pick(1, 8));
        end
        next_tag     = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        wait_cnt     = 0;
        accept_delay = pick(0, 3);
      end else if (s_cmd != mem_bus_pkg::BUS_NONE) begin
        wait_cnt++;
      end
      #1;
      mem2proc_tag  = mem_bus_pkg::TAG_NONE;
      mem2proc_data = '0;
      for (int i = 0; i < ret_due.size(); i++) begin
        if (ret_due[i] <= cycle && mem2proc_tag == mem_bus_pkg::TAG_NONE) begin
          mem2proc_tag  = ret_tag[i];  // One return per cycle
          mem2proc_data = ret_data[i];
          ret_tag.delete(i);
          ret_data.delete(i);
          ret_due.delete(i);
        end
      end
      mem2proc_response = (proc2mem_command != mem_bus_pkg::BUS_NONE &&
                           wait_cnt >= accept_delay) ? next_tag : mem_bus_pkg::TAG_NONE;
    end
  end

endmodule

// ==== mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_subsys (
  input  logic                   clock,
  input  logic                   arst_n,
  input  logic                   ic_cyc,
  input  logic                   ic_stb,
  input  logic [`CPU_ADDR_W-1:0] ic_adr,
  output logic [`XLEN-1:0]       ic_dat_r,
  output logic                   ic_ack,
  input  logic                   dc_cyc,
  input  logic                   dc_stb,
  input  logic                   dc_we,
  input  logic [`CPU_ADDR_W-1:0] dc_adr,
  input  logic [`XLEN-1:0]       dc_dat_w,
  output logic [`XLEN-1:0]       dc_dat_r,
  output logic                   dc_ack,
  output mem_bus_pkg::bus_cmd_e  proc2mem_command,
  output logic [`XLEN-1:0]       proc2mem_addr,
  output logic [`XLEN-1:0]       proc2mem_data,
  input  mem_bus_pkg::mem_tag_t  mem2proc_response,
  input  logic [`XLEN-1:0]       mem2proc_data,
  input  mem_bus_pkg::mem_tag_t  mem2proc_tag
);

  // Icache array wires
  icache_pkg::ic_idx_t   ic_rd_idx;
  icache_pkg::ic_tag_t   ic_rd_tag;
  logic [`XLEN-1:0]      ic_rd_data;
  logic                  ic_rd_hit;
  logic                  ic_wr_en;
  icache_pkg::ic_idx_t   ic_wr_idx;
  icache_pkg::ic_tag_t   ic_wr_tag;

  // Per-side bus requests
  mem_bus_pkg::bus_cmd_e i_cmd;
  logic [`XLEN-1:0]      i_addr;
  mem_bus_pkg::mem_tag_t i_response;
  mem_bus_pkg::bus_cmd_e d_cmd;
  logic [`XLEN-1:0]      d_addr;
  logic [`XLEN-1:0]      d_wdata;
  mem_bus_pkg::mem_tag_t d_response;

  icache_mem u_icache_mem (
    .clock   (clock),
    .arst_n  (arst_n),
    .wr_en   (ic_wr_en),
    .wr_idx  (ic_wr_idx),
    .wr_tag  (ic_wr_tag),
    .wr_data (mem2proc_data),  // Fill straight from the bus
    .rd_idx  (ic_rd_idx),
    .rd_tag  (ic_rd_tag),
    .rd_data (ic_rd_data),
    .rd_hit  (ic_rd_hit)
  );

  icache_ctrl u_icache_ctrl (
    .clock        (clock),
    .arst_n       (arst_n),
    .ic_cyc       (ic_cyc),
    .ic_stb       (ic_stb),
    .ic_adr       (ic_adr),
    .ic_dat_r     (ic_dat_r),
    .ic_ack       (ic_ack),
    .rd_idx       (ic_rd_idx),
    .rd_tag       (ic_rd_tag),
    .rd_data      (ic_rd_data),
    .rd_hit       (ic_rd_hit),
    .wr_en        (ic_wr_en),
    .wr_idx       (ic_wr_idx),
    .wr_tag       (ic_wr_tag),
    .mem_cmd      (i_cmd),
    .mem_addr     (i_addr),
    .mem_response (i_response),
    .mem_tag      (mem2proc_tag),
    .mem_data     (mem2proc_data)
  );

  dmem_port u_dmem_port (
    .clock        (clock),
    .arst_n       (arst_n),
    .dc_cyc       (dc_cyc),
    .dc_stb       (dc_stb),
    .dc_we        (dc_we),
    .dc_adr       (dc_adr),
    .dc_dat_w     (dc_dat_w),
    .dc_dat_r     (dc_dat_r),
    .dc_ack       (dc_ack),
    .mem_cmd      (d_cmd),
    .mem_addr     (d_addr),
    .mem_wdata    (d_wdata),
    .mem_response (d_response),
    .mem_tag      (mem2proc_tag),
    .mem_data     (mem2proc_data)
  );

  mem_arbiter u_mem_arbiter (
    .d_cmd             (d_cmd),
    .d_addr            (d_addr),
    .d_data            (d_wdata),
    .i_cmd             (i_cmd),
    .i_addr            (i_addr),
    .mem2proc_response (mem2proc_response),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .d_response        (d_response),
    .i_response        (i_response)
  );

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_arbiter (
  input  mem_bus_pkg::bus_cmd_e d_cmd,
  input  logic [`XLEN-1:0]      d_addr,
  input  logic [`XLEN-1:0]      d_data,
  input  mem_bus_pkg::bus_cmd_e i_cmd,
  input  logic [`XLEN-1:0]      i_addr,
  input  mem_bus_pkg::mem_tag_t mem2proc_response,
  output mem_bus_pkg::bus_cmd_e proc2mem_command,
  output logic [`XLEN-1:0]      proc2mem_addr,
  output logic [`XLEN-1:0]      proc2mem_data,
  output mem_bus_pkg::mem_tag_t d_response,
  output mem_bus_pkg::mem_tag_t i_response
);

  logic d_sel;  // Data side owns the bus

  assign d_sel = (d_cmd != mem_bus_pkg::BUS_NONE);

  assign proc2mem_command = d_sel ? d_cmd : i_cmd;
  assign proc2mem_addr    = d_sel ? d_addr : i_addr;
  assign proc2mem_data    = d_sel ? d_data : '0;  // Fetch side never stores

  // Acceptance only counts for the side on the bus
  assign d_response = d_sel ? mem2proc_response : mem_bus_pkg::TAG_NONE;
  assign i_response = d_sel ? mem_bus_pkg::TAG_NONE : mem2proc_response;

endmodule

// ==== dmem_port.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module dmem_port (
  input  logic                   clock,
  input  logic                   arst_n,
  input  logic                   dc_cyc,
  input  logic                   dc_stb,
  input  logic                   dc_we,
  input  logic [`CPU_ADDR_W-1:0] dc_adr,
  input  logic [`XLEN-1:0]       dc_dat_w,
  output logic [`XLEN-1:0]       dc_dat_r,
  output logic                   dc_ack,
  output mem_bus_pkg::bus_cmd_e  mem_cmd,
  output logic [`XLEN-1:0]       mem_addr,
  output logic [`XLEN-1:0]       mem_wdata,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  input  mem_bus_pkg::mem_tag_t  mem_tag,
  input  logic [`XLEN-1:0]       mem_data
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_ACK
  } state_e;

  state_e                 state_q;
  logic                   we_q;
  logic [`CPU_ADDR_W-1:0] adr_q;
  logic [`XLEN-1:0]       wdata_q;
  mem_bus_pkg::mem_tag_t  tag_q;
  logic                   accepted;
  logic                   load_done;

  assign mem_cmd   = (state_q != S_REQ) ? mem_bus_pkg::BUS_NONE :
                     we_q               ? mem_bus_pkg::BUS_STORE : mem_bus_pkg::BUS_LOAD;
  assign mem_addr  = `XLEN'(adr_q);
  assign mem_wdata = wdata_q;
  assign accepted  = (state_q == S_REQ) && (mem_response != mem_bus_pkg::TAG_NONE);
  assign load_done = (state_q == S_WAIT) && (mem_tag == tag_q);
  assign dc_ack    = (state_q == S_ACK);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_IDLE;
      tag_q   <= mem_bus_pkg::TAG_NONE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (dc_cyc && dc_stb) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (accepted) begin
            tag_q   <= mem_response;
            state_q <= we_q ? S_ACK : S_WAIT;  // Store done on acceptance
          end
        end
        S_WAIT: begin
          if (load_done) begin
            state_q <= S_ACK;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == S_IDLE && dc_cyc && dc_stb) begin
      we_q    <= dc_we;
      adr_q   <= dc_adr;
      wdata_q <= dc_dat_w;
    end
    if (load_done) begin
      dc_dat_r <= mem_data;
    end
  end

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module icache_ctrl (
  input  logic                   clock,
  input  logic                   arst_n,
  input  logic                   ic_cyc,
  input  logic                   ic_stb,
  input  logic [`CPU_ADDR_W-1:0] ic_adr,
  output logic [`XLEN-1:0]       ic_dat_r,
  output logic                   ic_ack,
  output icache_pkg::ic_idx_t    rd_idx,
  output icache_pkg::ic_tag_t    rd_tag,
  input  logic [`XLEN-1:0]       rd_data,
  input  logic                   rd_hit,
  output logic                   wr_en,
  output icache_pkg::ic_idx_t    wr_idx,
  output icache_pkg::ic_tag_t    wr_tag,
  output mem_bus_pkg::bus_cmd_e  mem_cmd,
  output logic [`XLEN-1:0]       mem_addr,
  input  mem_bus_pkg::mem_tag_t  mem_response,
  input  mem_bus_pkg::mem_tag_t  mem_tag,
  input  logic [`XLEN-1:0]       mem_data
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_REQUEST,
    S_WAIT_FILL,
    S_ACK
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  logic [`CPU_ADDR_W-1:0] adr_q;
  mem_bus_pkg::mem_tag_t  tag_q;     // Tag of the outstanding line request
  logic                   miss;
  logic                   accepted;
  logic                   fill;

  assign rd_idx = icache_pkg::addr_idx(adr_q);
  assign rd_tag = icache_pkg::addr_tag(adr_q);
  assign wr_idx = rd_idx;            // Fill goes to the line that missed
  assign wr_tag = rd_tag;

  // Miss request starts already in the lookup cycle
  assign miss     = (state_q == S_LOOKUP) && !rd_hit;
  assign mem_cmd  = (miss || state_q == S_REQUEST) ? mem_bus_pkg::BUS_LOAD
                                                   : mem_bus_pkg::BUS_NONE;
  assign mem_addr = `XLEN'(icache_pkg::line_addr(rd_tag, rd_idx));
  assign accepted = (mem_cmd == mem_bus_pkg::BUS_LOAD) &&
                    (mem_response != mem_bus_pkg::TAG_NONE);
  assign fill     = (state_q == S_WAIT_FILL) && (mem_tag == tag_q);
  assign wr_en    = fill;
  assign ic_ack   = (state_q == S_ACK);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (ic_cyc && ic_stb) begin
          state_d = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (rd_hit) begin
          state_d = S_ACK;
        end else if (accepted) begin
          state_d = S_WAIT_FILL;
        end else begin
          state_d = S_REQUEST;
        end
      end
      S_REQUEST: begin
        if (accepted) begin
          state_d = S_WAIT_FILL;
        end
      end
      S_WAIT_FILL: begin
        if (fill) begin
          state_d = S_ACK;
        end
      end
      S_ACK:   state_d = S_IDLE;  // Master drops stb after the ack
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_IDLE;
      tag_q   <= mem_bus_pkg::TAG_NONE;
    end else begin
      state_q <= state_d;
      if (accepted) begin
        tag_q <= mem_response;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == S_IDLE && ic_cyc && ic_stb) begin
      adr_q <= ic_adr;
    end
    if (state_q == S_LOOKUP && rd_hit) begin
      ic_dat_r <= rd_data;
    end else if (fill) begin
      ic_dat_r <= mem_data;  // Forward the fill, no second lookup
    end
  end

endmodule

// ==== icache_mem.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module icache_mem (
  input  logic                clock,
  input  logic                arst_n,
  input  logic                wr_en,
  input  icache_pkg::ic_idx_t wr_idx,
  input  icache_pkg::ic_tag_t wr_tag,
  input  logic [`XLEN-1:0]    wr_data,
  input  icache_pkg::ic_idx_t rd_idx,
  input  icache_pkg::ic_tag_t rd_tag,
  output logic [`XLEN-1:0]    rd_data,
  output logic                rd_hit
);

  logic [`XLEN-1:0]    data_mem [0:`IC_LINES-1];
  icache_pkg::ic_tag_t tag_mem  [0:`IC_LINES-1];
  logic [`IC_LINES-1:0] valid_q;

  // Valid bits, all lines start empty
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  assign rd_data = data_mem[rd_idx];  // Async read
  assign rd_hit  = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

endmodule

// ==== icache_pkg.sv ====
`include "mem_config.svh"

package icache_pkg;

  localparam int OFS_W = $clog2(`XLEN / 8);  // Byte offset in a doubleword

  typedef logic [`IC_IDX_W-1:0] ic_idx_t;
  typedef logic [`IC_TAG_W-1:0] ic_tag_t;

  function automatic ic_idx_t addr_idx(input logic [`CPU_ADDR_W-1:0] adr);
    return adr[OFS_W +: `IC_IDX_W];
  endfunction

  function automatic ic_tag_t addr_tag(input logic [`CPU_ADDR_W-1:0] adr);
    return adr[OFS_W + `IC_IDX_W +: `IC_TAG_W];
  endfunction

  // Byte address of the first byte in a line
  function automatic logic [`CPU_ADDR_W-1:0] line_addr(input ic_tag_t tag, input ic_idx_t idx);
    return {tag, idx, {OFS_W{1'b0}}};
  endfunction

endpackage

// ==== mem_bus_pkg.sv ====
`include "mem_config.svh"

package mem_bus_pkg;

  // Command on the processor to memory bus
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // Tag returned on acceptance and again with the load data
  typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

  localparam mem_tag_t TAG_NONE = '0;  // No command accepted / no data

endpackage

// ==== mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Data path and memory address width
`define XLEN 64

// Byte address width seen on the fetch and data ports
`define CPU_ADDR_W 16

// Direct-mapped icache, one doubleword per line
`define IC_IDX_W 5
`define IC_TAG_W 8
`define IC_LINES 32

// Memory transaction tag, zero means no tag
`define MEM_TAG_W 4

`endif
